//--- design/div_pkg.sv
// shared div types and constants; op codes follow RISC-V funct3, codes 0..3 behave as DIVU
package div_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////////////////////////

    // operand width used by default in every module
    localparam int XLEN_DEFAULT = 32;

    //////////////////////////////////////////////////////////////////////
    // encodings
    //////////////////////////////////////////////////////////////////////

    // M-extension funct3 for the divide group
    typedef enum logic [2:0] {
        DIV_OP_DIV  = 3'd4,
        DIV_OP_DIVU = 3'd5,
        DIV_OP_REM  = 3'd6,
        DIV_OP_REMU = 3'd7
    } div_op_e;

    // controller states, only div_ctrl uses them
    // kept here so waveforms show the state names
    typedef enum logic [1:0] {
        ST_IDLE = 2'b00,
        ST_PRE  = 2'b01,
        ST_BUSY = 2'b10,
        ST_FIX  = 2'b11
    } div_state_e;

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    // bits needed to hold the value xlen in the step counter
    function automatic int div_cnt_width(input int xlen);
        return $clog2(xlen + 1);
    endfunction

endpackage

//--- design/div_ctrl.sv
// sequencer for accept, pre-handle, XLEN steps and finish; op_stall freezes every state
`timescale 1ns/100ps

module div_ctrl #(
    parameter int XLEN = div_pkg::XLEN_DEFAULT
) (
    input  logic clk,
    input  logic rst_n,

    input  logic op_valid,
    input  logic op_stall,

    output logic start,
    output logic pre,
    output logic step,
    output logic finish
);

    import div_pkg::*;

    localparam int CNT_W = div_cnt_width(XLEN);

    div_state_e         state;
    div_state_e         state_nxt;
    logic [CNT_W-1:0]   cnt;
    logic               last_step;

    //////////////////////////////////////////////////////////////////////
    // strobes
    //////////////////////////////////////////////////////////////////////

    // each strobe is one-hot by state and dies under stall
    assign start  = (state == ST_IDLE) && op_valid && !op_stall;
    assign pre    = (state == ST_PRE)  && !op_stall;
    assign step   = (state == ST_BUSY) && !op_stall;
    assign finish = (state == ST_FIX)  && !op_stall;

    assign last_step = (cnt == CNT_W'(1));

    //////////////////////////////////////////////////////////////////////
    // state machine
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (start) begin
                    state_nxt = ST_PRE;
                end
            end
            ST_PRE: begin
                if (pre) begin
                    state_nxt = ST_BUSY;
                end
            end
            ST_BUSY: begin
                // leave after the XLEN-th step
                if (step && last_step) begin
                    state_nxt = ST_FIX;
                end
            end
            ST_FIX: begin
                if (finish) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // step counter
    //////////////////////////////////////////////////////////////////////

    // loaded in pre-handle, counts down once per step
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (pre) begin
            cnt <= CNT_W'(XLEN);
        end else if (step) begin
            cnt <= cnt - 1'b1;
        end
    end

endmodule

//--- design/div_sign.sv
// signs count for DIV/REM only; op_out is combinational and zero outside the finish cycle
`timescale 1ns/100ps

module div_sign #(
    parameter int XLEN = div_pkg::XLEN_DEFAULT
) (
    input  logic                clk,
    input  logic                rst_n,

    input  logic                start,
    input  logic                finish,

    input  div_pkg::div_op_e    op,
    input  logic [XLEN-1:0]     op1,
    input  logic [XLEN-1:0]     op2,

    output logic [XLEN-1:0]     dvd_mag,
    output logic [XLEN-1:0]     dvs_mag,
    input  logic [XLEN-1:0]     quot,
    input  logic [XLEN-1:0]     rem,

    output logic [XLEN-1:0]     op_out
);

    import div_pkg::*;

    logic            is_signed;
    logic            op1_neg;
    logic            op2_neg;

    // captured at accept
    logic            rem_sel_q;
    logic            dvd_neg_q;
    logic            dvs_neg_q;
    logic [XLEN-1:0] op2_q;

    logic            quot_neg;
    logic [XLEN-1:0] quot_fix;
    logic [XLEN-1:0] rem_fix;

    //////////////////////////////////////////////////////////////////////
    // operand magnitudes
    //////////////////////////////////////////////////////////////////////

    // codes 0..3 fall through as unsigned
    assign is_signed = (op == DIV_OP_DIV) || (op == DIV_OP_REM);
    assign op1_neg   = is_signed && op1[XLEN-1];
    assign op2_neg   = is_signed && op2[XLEN-1];

    // most negative value maps onto itself, which is the right unsigned magnitude
    assign dvd_mag = op1_neg ? (~op1 + 1'b1) : op1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rem_sel_q <= 1'b0;
            dvd_neg_q <= 1'b0;
            dvs_neg_q <= 1'b0;
            op2_q     <= '0;
        end else if (start) begin
            rem_sel_q <= (op == DIV_OP_REM) || (op == DIV_OP_REMU);
            dvd_neg_q <= op1_neg;
            dvs_neg_q <= op2_neg;
            op2_q     <= op2;
        end
    end

    // divisor magnitude from the held copy, used one cycle after accept
    assign dvs_mag = dvs_neg_q ? (~op2_q + 1'b1) : op2_q;

    //////////////////////////////////////////////////////////////////////
    // result sign fix
    //////////////////////////////////////////////////////////////////////

    // divide by zero keeps the all-ones quotient unsigned
    assign quot_neg = (dvd_neg_q ^ dvs_neg_q) && (op2_q != '0);

    assign quot_fix = quot_neg  ? (~quot + 1'b1) : quot;
    // remainder follows the dividend sign
    assign rem_fix  = dvd_neg_q ? (~rem + 1'b1)  : rem;

    assign op_out = finish ? (rem_sel_q ? rem_fix : quot_fix) : '0;

endmodule

//--- design/div_datapath.sv
// radix-2 restoring divider on unsigned magnitudes; a zero divisor yields an all-ones quotient
`timescale 1ns/100ps

module div_datapath #(
    parameter int XLEN = div_pkg::XLEN_DEFAULT
) (
    input  logic            clk,
    input  logic            rst_n,

    input  logic            start,
    input  logic            pre,
    input  logic            step,

    input  logic [XLEN-1:0] dvd_mag,
    input  logic [XLEN-1:0] dvs_mag,

    output logic [XLEN-1:0] quot,
    output logic [XLEN-1:0] rem
);

    // remainder in the upper half, quotient in the lower half
    logic [2*XLEN-1:0] work;
    logic [XLEN-1:0]   dvs_q;

    // partial remainder after the shift, one bit wider than XLEN
    logic [XLEN:0]     part;
    logic [XLEN:0]     diff;
    logic              ge;
    logic [2*XLEN-1:0] work_nxt;

    //////////////////////////////////////////////////////////////////////
    // one shift-subtract step
    //////////////////////////////////////////////////////////////////////

    // old remainder shifted left with the next dividend bit brought in
    assign part = work[2*XLEN-1:XLEN-1];
    assign diff = part - {1'b0, dvs_q};

    // no borrow means the divisor fits
    assign ge = ~diff[XLEN];

    always_comb begin
        work_nxt[XLEN-1:0] = {work[XLEN-2:0], ge};
        if (ge) begin
            work_nxt[2*XLEN-1:XLEN] = diff[XLEN-1:0];
        end else begin
            work_nxt[2*XLEN-1:XLEN] = part[XLEN-1:0];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            work <= '0;
        end else if (start) begin
            work <= {{XLEN{1'b0}}, dvd_mag};
        end else if (step) begin
            work <= work_nxt;
        end
    end

    // divisor magnitude arrives in the pre-handle cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dvs_q <= '0;
        end else if (pre) begin
            dvs_q <= dvs_mag;
        end
    end

    assign quot = work[XLEN-1:0];
    assign rem  = work[2*XLEN-1:XLEN];

endmodule

//--- design/div_unit.sv
// fixed latency of XLEN+2 unstalled cycles after accept; one operation in flight
`timescale 1ns/100ps

module div_unit #(
    parameter int XLEN = div_pkg::XLEN_DEFAULT
) (
    input  logic                clk,
    input  logic                rst_n,

    input  logic                op_valid,
    input  logic                op_stall,
    output logic                op_ready,
    input  div_pkg::div_op_e    op,
    input  logic [XLEN-1:0]     op1,
    input  logic [XLEN-1:0]     op2,
    output logic [XLEN-1:0]     op_out
);

    // stall-gated strobes from the controller
    logic            start;
    logic            pre;
    logic            step;
    logic            finish;

    // magnitudes into the datapath, raw results back out
    logic [XLEN-1:0] dvd_mag;
    logic [XLEN-1:0] dvs_mag;
    logic [XLEN-1:0] quot;
    logic [XLEN-1:0] rem;

    div_ctrl #(.XLEN(XLEN)) ctrl_u (
        .clk      (clk),
        .rst_n    (rst_n),
        .op_valid (op_valid),
        .op_stall (op_stall),
        .start    (start),
        .pre      (pre),
        .step     (step),
        .finish   (finish)
    );

    div_sign #(.XLEN(XLEN)) sign_u (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .finish   (finish),
        .op       (op),
        .op1      (op1),
        .op2      (op2),
        .dvd_mag  (dvd_mag),
        .dvs_mag  (dvs_mag),
        .quot     (quot),
        .rem      (rem),
        .op_out   (op_out)
    );

    div_datapath #(.XLEN(XLEN)) dp_u (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .pre      (pre),
        .step     (step),
        .dvd_mag  (dvd_mag),
        .dvs_mag  (dvs_mag),
        .quot     (quot),
        .rem      (rem)
    );

    // result is only valid in the unstalled finish cycle
    assign op_ready = finish;

endmodule

//--- include/div_ref.svh
// behavioural RISC-V divide model at XLEN_DEFAULT width; needs div_pkg compiled first
`ifndef DIV_REF_SVH
`define DIV_REF_SVH

//////////////////////////////////////////////////////////////////////
// expected result for DIV, DIVU, REM and REMU
//////////////////////////////////////////////////////////////////////

function automatic logic [div_pkg::XLEN_DEFAULT-1:0] div_ref(
    input div_pkg::div_op_e                  op,
    input logic [div_pkg::XLEN_DEFAULT-1:0]  op1,
    input logic [div_pkg::XLEN_DEFAULT-1:0]  op2
);
    logic signed [div_pkg::XLEN_DEFAULT-1:0] s1;
    logic signed [div_pkg::XLEN_DEFAULT-1:0] s2;
    logic        [div_pkg::XLEN_DEFAULT-1:0] q;
    logic        [div_pkg::XLEN_DEFAULT-1:0] r;
    logic        [div_pkg::XLEN_DEFAULT-1:0] min_neg;
    logic                                    sgn;
    logic                                    rem_sel;

    s1      = op1;
    s2      = op2;
    min_neg = {1'b1, {(div_pkg::XLEN_DEFAULT-1){1'b0}}};
    sgn     = (op == div_pkg::DIV_OP_DIV) || (op == div_pkg::DIV_OP_REM);
    rem_sel = (op == div_pkg::DIV_OP_REM) || (op == div_pkg::DIV_OP_REMU);

    if (op2 == '0) begin
        // divide by zero
        q = '1;
        r = op1;
    end else if (sgn && (op1 == min_neg) && (op2 == '1)) begin
        // signed overflow
        q = min_neg;
        r = '0;
    end else if (sgn) begin
        // truncates toward zero, remainder keeps the dividend sign
        q = s1 / s2;
        r = s1 % s2;
    end else begin
        q = op1 / op2;
        r = op1 % op2;
    end

    return rem_sel ? r : q;
endfunction

`endif

//--- verif/div_unit_tb.sv
// testbench for div_unit at XLEN_DEFAULT; stall process uses its own random stream per thread
`timescale 1ns/100ps

module div_unit_tb;

    import div_pkg::*;

    `include "div_ref.svh"

    localparam int W           = XLEN_DEFAULT;
    localparam int LATENCY     = W + 2;
    localparam int MAX_STALL   = 5;
    localparam int CLK_PERIOD  = 100;
    localparam int SEED        = 32'h445a;

    localparam int N_UNSIGNED  = 200;
    localparam int N_SIGNED    = 200;
    localparam int N_VALS      = 6;
    localparam int N_CORNER    = 4 * N_VALS * N_VALS;
    localparam int N_LATENCY   = 10;
    localparam int N_STALL     = 100;
    localparam int N_OPS       = N_UNSIGNED + N_SIGNED + N_CORNER + N_LATENCY + N_STALL;
    localparam int WATCHDOG_NS = N_OPS * (LATENCY + MAX_STALL + 2) * CLK_PERIOD;

    logic           clk;
    logic           rst_n;
    logic           op_valid;
    logic           op_stall;
    logic           op_ready;
    div_op_e        op;
    logic [W-1:0]   op1;
    logic [W-1:0]   op2;
    logic [W-1:0]   op_out;

    bit             stall_on;

    div_unit #(.XLEN(W)) UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .op_valid (op_valid),
        .op_stall (op_stall),
        .op_ready (op_ready),
        .op       (op),
        .op1      (op1),
        .op2      (op2),
        .op_out   (op_out)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////////////////////////

    // mix of full range, shifted down, small and near all ones
    function automatic logic [W-1:0] rand_unsigned();
        logic [W-1:0] v;
        case ($urandom_range(3, 0))
            0: v = W'($urandom);
            1: v = W'($urandom) >> $urandom_range(W - 1, 0);
            2: v = W'($urandom_range(255, 0));
            default: v = ~W'($urandom_range(255, 0));
        endcase
        return v;
    endfunction

    // three in four non-negative draws get negated
    function automatic logic [W-1:0] rand_signed();
        logic [W-1:0] v;
        v = rand_unsigned();
        if (!v[W-1] && ($urandom_range(3, 0) != 0)) begin
            v = ~v + 1'b1;
        end
        return v;
    endfunction

    // called and returning 10 ns after a rising edge
    task automatic issue_op(input div_op_e o, input logic [W-1:0] a, input logic [W-1:0] b);
        op_valid = 1'b1;
        op       = o;
        op1      = a;
        op2      = b;
        do begin
            @(negedge clk);
        end while (op_ready !== 1'b1);
        @(posedge clk);
        #10;
        op_valid = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // stall generator
    //////////////////////////////////////////////////////////////////////

    initial begin : stall_gen
        int run_left;
        bit stall_nxt;
        run_left = 0;
        op_stall = 1'b0;
        forever begin
            @(posedge clk);
            #5;
            if (run_left > 0) begin
                stall_nxt = 1'b1;
                run_left  = run_left - 1;
            end else begin
                stall_nxt = 1'b0;
                if (stall_on && ($urandom_range(15, 0) == 0)) begin
                    run_left = $urandom_range(MAX_STALL, 1);
                end
            end
            #5;
            op_stall = stall_nxt;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // comparing process sampling at the falling edge
    //////////////////////////////////////////////////////////////////////

    initial begin : compare_results
        bit           busy;
        int           cycles;
        int           stalls;
        div_op_e      held_op;
        logic [W-1:0] held_a;
        logic [W-1:0] held_b;
        logic [W-1:0] expected;
        busy      = 1'b0;
        cycles    = 0;
        stalls    = 0;
        @(posedge rst_n);
        forever begin
            @(negedge clk);
            assert (!(op_ready && op_stall)) else begin
                $display("op_ready was high in a cycle with op_stall high");
                $display("Result: FAILED");
                $fatal(1, "ready during stall");
            end
            if (op_ready !== 1'b1) begin
                assert (op_out === '0) else begin
                    $display("FAILED op_out expected %h actual %h", {W{1'b0}}, op_out);
                    $display("Result: FAILED");
                    $fatal(1, "op_out not zero outside finish");
                end
            end
            if (busy) begin
                cycles = cycles + 1;
                if (op_ready === 1'b1) begin
                    assert (cycles == LATENCY + stalls) else begin
                        $display("FAILED latency expected %h actual %h",
                                 LATENCY + stalls, cycles);
                        $display("Result: FAILED");
                        $fatal(1, "wrong latency");
                    end
                    expected = div_ref(held_op, held_a, held_b);
                    assert (op_out === expected) else begin
                        $display("FAILED op_out expected %h actual %h (op %0d op1 %h op2 %h)",
                                 expected, op_out, held_op, held_a, held_b);
                        $display("Result: FAILED");
                        $fatal(1, "wrong result");
                    end
                    busy      = 1'b0;
                end else if (op_stall) begin
                    stalls = stalls + 1;
                end
            end else begin
                assert (op_ready !== 1'b1) else begin
                    $display("op_ready went high with no operation in flight");
                    $display("Result: FAILED");
                    $fatal(1, "spurious ready");
                end
                // the next rising edge accepts
                if (op_valid && !op_stall) begin
                    busy    = 1'b1;
                    cycles  = 0;
                    stalls  = 0;
                    held_op = op;
                    held_a  = op1;
                    held_b  = op2;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout: the operations did not complete in %0d ns", WATCHDOG_NS);
        $display("Result: FAILED");
        $fatal(1, "watchdog expired");
    end

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin : main_seq
        logic [W-1:0] vals [N_VALS];
        div_op_e      ops [4];
        div_op_e      o;
        void'($urandom(SEED));
        vals     = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff, 32'h7};
        ops      = '{DIV_OP_DIV, DIV_OP_DIVU, DIV_OP_REM, DIV_OP_REMU};
        rst_n    = 1'b0;
        op_valid = 1'b0;
        op       = DIV_OP_DIVU;
        op1      = '0;
        op2      = '0;
        stall_on = 1'b0;
        repeat (3) @(posedge clk);
        #10;
        rst_n = 1'b1;

        // idle after reset
        repeat (10) begin
            @(negedge clk);
            assert (op_ready === 1'b0) else begin
                $display("op_ready was not low while idle after reset");
                $display("Result: FAILED");
                $fatal(1, "ready after reset");
            end
        end
        @(posedge clk);
        #10;

        for (int i = 0; i < N_UNSIGNED; i++) begin
            o = ($urandom_range(1, 0) != 0) ? DIV_OP_REMU : DIV_OP_DIVU;
            issue_op(o, rand_unsigned(), rand_unsigned());
        end

        for (int i = 0; i < N_SIGNED; i++) begin
            o = ($urandom_range(1, 0) != 0) ? DIV_OP_REM : DIV_OP_DIV;
            issue_op(o, rand_signed(), rand_signed());
        end

        // zero divisor, overflow, zero, one and all ones in every pairing
        for (int k = 0; k < 4; k++) begin
            for (int i = 0; i < N_VALS; i++) begin
                for (int j = 0; j < N_VALS; j++) begin
                    issue_op(ops[k], vals[i], vals[j]);
                end
            end
        end

        for (int i = 0; i < N_LATENCY; i++) begin
            issue_op(ops[$urandom_range(3, 0)], rand_signed(), rand_unsigned());
        end

        stall_on = 1'b1;
        for (int i = 0; i < N_STALL; i++) begin
            issue_op(ops[$urandom_range(3, 0)], rand_signed(), rand_signed());
        end
        stall_on = 1'b0;

        repeat (2) @(posedge clk);
        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- div_unit.f
+incdir+include
design/div_pkg.sv
design/div_ctrl.sv
design/div_sign.sv
design/div_datapath.sv
design/div_unit.sv
verif/div_unit_tb.sv
